// ==== sim/flow_cache_input.txt ====
# P/E: record hex = key(128) count(32) time(32) hash index(32)
# W/R: table address hex, entry hex = key(128) count(32) time(32); S: stall cycles
# insert into empty slot 0x0010
P 0123456789abcdef0011223344556677000000000000100000000010
R 0010 0123456789abcdef00112233445566770000000100001000
# hit, count 2 and newer time
P 0123456789abcdef0011223344556677000000000000200000000010
R 0010 0123456789abcdef00112233445566770000000200002000
# overflow, fresh entry keeps slot
P fedcba9876543210aabbccddeeff0011000000050001000000000010
E fedcba9876543210aabbccddeeff0011000000050001000000000010
R 0010 0123456789abcdef00112233445566770000000200002000
# eviction, old entry out with incoming index
P 00000000000000000000000000c0ffee000000000003000000010010
E 0123456789abcdef0011223344556677000000020000200000010010
R 0010 00000000000000000000000000c0ffee0000000100030000
# bus write then hit
W 0123 111111112222222233333333444444440000000700005000
P 11111111222222223333333344444444000000000000600000000123
R 0123 111111112222222233333333444444440000000800006000
# overflow burst under downstream stall
S 30
P 5555555566666666777777778888888a000000010000700000000123
P 5555555566666666777777778888888b000000020000710000000123
P 5555555566666666777777778888888c000000030000720000000123
P 0123456789abcdef0011223344556677000000090003010000000010
E 5555555566666666777777778888888a000000010000700000000123
E 5555555566666666777777778888888b000000020000710000000123
E 5555555566666666777777778888888c000000030000720000000123
E 0123456789abcdef0011223344556677000000090003010000000010
R 0123 111111112222222233333333444444440000000800006000
R 0010 00000000000000000000000000c0ffee0000000100030000
# top slot, only low 14 index bits address the table
P 99999999aaaaaaaabbbbbbbbcccccccc0000000000040000ffffffff
R 3fff 99999999aaaaaaaabbbbbbbbcccccccc0000000100040000

// ==== list.f ====
src/flow_pkg.sv
src/key_fifo.sv
src/flow_table_ram.sv
src/flow_lookup.sv
src/mgmt_bus.sv
src/flow_cache_top.sv
sim/flow_checker.sv
sim/tb_flow_cache.sv

// ==== Makefile ====
TOP := tb_flow_cache

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -j 0 --top-module $(TOP) -f list.f

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "All tests passed"

lint:
	verilator --lint-only --timing --top-module $(TOP) -f list.f

clean:
	rm -rf obj_dir

// ==== sim/tb_flow_cache.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_flow_cache;

	logic							Clk;
	logic							Reset_N;
	flow_pkg::flow_rec_t			key_in;
	logic							key_in_wr;
	logic							key_in_afull;
	flow_pkg::flow_rec_t			key_out;
	logic							key_out_wr;
	logic							out_afull;
	logic							bus_cs_n;
	logic							bus_rw;
	flow_pkg::table_addr_t			bus_addr;
	flow_pkg::table_entry_t			bus_wdata;
	flow_pkg::table_entry_t			bus_rdata;
	logic							bus_ack_n;

	string		lines [$];									// data file, one per line
	int			num_lines = 0;
	int			pending = 0;								// pushes since last settle
	int			proto_errs = 0;								// handshake and parse errors
	int			stall_len = 0;
	int			total_errs;
	logic		file_ok;

	initial Clk = 1'b0;
	always #10 Clk = ~Clk;									// 20 ns period

	flow_cache_top u_flow_cache_top (
		.Clk			(Clk),
		.Reset_N		(Reset_N),
		.key_in			(key_in),
		.key_in_wr		(key_in_wr),
		.key_in_afull	(key_in_afull),
		.key_out		(key_out),
		.key_out_wr		(key_out_wr),
		.out_afull		(out_afull),
		.bus_cs_n		(bus_cs_n),
		.bus_rw			(bus_rw),
		.bus_addr		(bus_addr),
		.bus_wdata		(bus_wdata),
		.bus_rdata		(bus_rdata),
		.bus_ack_n		(bus_ack_n)
	);

	flow_checker u_flow_checker (
		.Clk			(Clk),
		.Reset_N		(Reset_N),
		.key_in_wr		(key_in_wr),
		.key_in_afull	(key_in_afull),
		.key_out		(key_out),
		.key_out_wr		(key_out_wr),
		.out_afull		(out_afull),
		.bus_rw			(bus_rw),
		.bus_rdata		(bus_rdata),
		.bus_ack_n		(bus_ack_n)
	);

	task automatic load_file(output logic ok);
		int		fd;
		string	line;
		fd = $fopen("sim/flow_cache_input.txt", "r");
		ok = (fd != 0);
		if (ok) begin
			while ($fgets(line, fd) != 0) begin
				lines.push_back(line);
			end
			$fclose(fd);
			num_lines = lines.size();
		end
	endtask

	// one-cycle strobe, respects the fifo almost-full level
	task automatic push_record(input flow_pkg::flow_rec_t rec);
		int		waited;
		waited = 0;
		@(posedge Clk);
		while (key_in_afull && waited < 200) begin
			@(posedge Clk);
			waited++;
		end
		if (key_in_afull) begin
			$display("Key FIFO stayed almost full at time %0t, record pushed anyway", $time);
			proto_errs++;
		end
		#1;
		key_in		= rec;
		key_in_wr	= 1'b1;
		@(posedge Clk);
		#1;
		key_in_wr	= 1'b0;
		pending++;
	endtask

	// let every pushed record finish: pop, read latency, decide, gap
	task automatic settle();
		wait (out_afull == 1'b0);
		repeat (pending * (flow_pkg::RAM_RD_LATENCY + 3) + 4) @(posedge Clk);
		#1;
		pending = 0;
	endtask

	task automatic bus_access(input logic rw, input flow_pkg::table_addr_t addr,
			input flow_pkg::table_entry_t wdata);
		int		waited;
		@(posedge Clk);
		#1;
		bus_cs_n	= 1'b0;
		bus_rw		= rw;
		bus_addr	= addr;
		bus_wdata	= wdata;
		@(posedge Clk);
		waited = 1;
		while (bus_ack_n && waited < 20) begin				// read acks after 5
			@(posedge Clk);
			waited++;
		end
		if (bus_ack_n) begin
			$display("Bus ack did not arrive for address %h at time %0t", addr, $time);
			proto_errs++;
		end
		#1;
		bus_cs_n = 1'b1;									// release
		@(posedge Clk);
		waited = 1;
		while (!bus_ack_n && waited < 20) begin
			@(posedge Clk);
			waited++;
		end
		if (!bus_ack_n) begin
			$display("Bus ack stayed low after chip select release at time %0t", $time);
			proto_errs++;
		end
		#1;
	endtask

	task automatic hold_stall(input int cycles);
		@(posedge Clk);
		#1;
		out_afull = 1'b1;
		repeat (cycles) @(posedge Clk);
		#1;
		out_afull = 1'b0;
	endtask

	// ============================================================
	// data file commands
	// ============================================================
	task automatic run_lines();
		string						line;
		byte						cmd;
		flow_pkg::flow_rec_t		rec;
		flow_pkg::table_entry_t		entry;
		logic [31:0]				addr;
		int							n;
		int							cnt;
		foreach (lines[i]) begin
			line = lines[i];
			cmd = (line.len() > 0) ? line.getc(0) : "#";
			if (line.len() >= 2 && cmd != "#") begin		// skip blanks and comments
				case (cmd)
					"P", "E": begin
						n = $sscanf(line, "%c %h", cmd, rec);
						if (n != 2) begin
							$display("Could not parse data line %0d", i + 1);
							proto_errs++;
						end else if (cmd == "P") begin
							push_record(rec);
						end else begin
							u_flow_checker.add_expected_rec(rec);
						end
					end
					"W", "R": begin
						n = $sscanf(line, "%c %h %h", cmd, addr, entry);
						if (n != 3) begin
							$display("Could not parse data line %0d", i + 1);
							proto_errs++;
						end else begin
							settle();						// table must hold pushed records
							if (cmd == "W") begin
								bus_access(1'b1, addr[flow_pkg::TABLE_ADDR_W-1:0], entry);
							end else begin
								u_flow_checker.add_expected_read(entry);
								bus_access(1'b0, addr[flow_pkg::TABLE_ADDR_W-1:0], '0);
							end
						end
					end
					"S": begin
						n = $sscanf(line, "%c %d", cmd, cnt);
						if (n != 2) begin
							$display("Could not parse data line %0d", i + 1);
							proto_errs++;
						end else begin
							stall_len = cnt;
							fork
								hold_stall(stall_len);		// pushes go on meanwhile
							join_none
						end
					end
					default: begin
						$display("Unknown command on data line %0d", i + 1);
						proto_errs++;
					end
				endcase
			end
		end
	endtask

	// ============================================================
	// main sequence
	// ============================================================
	initial begin
		Reset_N		= 1'b0;
		key_in		= '0;
		key_in_wr	= 1'b0;
		out_afull	= 1'b0;
		bus_cs_n	= 1'b1;
		bus_rw		= 1'b0;
		bus_addr	= '0;
		bus_wdata	= '0;
		load_file(file_ok);
		if (!file_ok) begin
			$display("Could not open sim/flow_cache_input.txt");
			$display("Some tests failed");
			$finish;
		end else begin
			repeat (4) @(posedge Clk);
			#1;
			Reset_N = 1'b1;
			run_lines();
			settle();
			repeat (4) @(posedge Clk);
			u_flow_checker.report_leftovers();
			total_errs = u_flow_checker.mismatch_cnt + u_flow_checker.unexpected_cnt
				+ u_flow_checker.missing_cnt + u_flow_checker.stall_cnt + proto_errs;
			$display("Errors: %0d mismatch, %0d unexpected, %0d missing, %0d stall, %0d protocol",
				u_flow_checker.mismatch_cnt, u_flow_checker.unexpected_cnt,
				u_flow_checker.missing_cnt, u_flow_checker.stall_cnt, proto_errs);
			if (total_errs == 0) begin
				$display("All tests passed");
			end else begin
				$display("Some tests failed");
			end
			$finish;
		end
	end

	// watchdog, 60 cycles per data line
	initial begin
		wait (num_lines > 0);
		repeat (num_lines * 60) @(posedge Clk);
		$display("Timeout after %0d cycles, the run did not finish", num_lines * 60);
		$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim/flow_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

module flow_checker (
	input  wire logic						Clk,
	input  wire logic						Reset_N,
	input  wire logic						key_in_wr,		// upstream push strobe
	input  wire logic						key_in_afull,
	input  wire flow_pkg::flow_rec_t		key_out,
	input  wire logic						key_out_wr,
	input  wire logic						out_afull,
	input  wire logic						bus_rw,			// held by host until ack
	input  wire flow_pkg::table_entry_t		bus_rdata,
	input  wire logic						bus_ack_n
);

	flow_pkg::flow_rec_t		exp_recs [$];				// expected key_out, in order
	flow_pkg::table_entry_t		exp_reads [$];				// expected bus read data
	int							mismatch_cnt = 0;
	int							unexpected_cnt = 0;			// output with nothing queued
	int							missing_cnt = 0;			// queued, never seen
	int							stall_cnt = 0;				// emitted during long stall
	int							afull_cycles = 0;			// consecutive stalled samples
	int							push_cnt = 0;				// records strobed in
	int							emit_cnt = 0;				// records seen on key_out
	logic						ack_q = 1'b1;				// last sampled ack

	task automatic add_expected_rec(input flow_pkg::flow_rec_t rec);
		exp_recs.push_back(rec);
	endtask

	task automatic add_expected_read(input flow_pkg::table_entry_t entry);
		exp_reads.push_back(entry);
	endtask

	// anything still queued at the end never showed up
	task automatic report_leftovers();
		if (exp_recs.size() != 0) begin
			$display("%0d expected output records never arrived", exp_recs.size());
		end
		if (exp_reads.size() != 0) begin
			$display("%0d expected bus reads never completed", exp_reads.size());
		end
		missing_cnt += exp_recs.size() + exp_reads.size();
	endtask

	// ============================================================
	// sample on the rising edge, values settled since edge+1
	// ============================================================
	always @(posedge Clk) begin
		flow_pkg::flow_rec_t		want_rec;
		flow_pkg::table_entry_t		want_entry;
		if (!Reset_N) begin
			ack_q			= 1'b1;
			afull_cycles	= 0;
		end else begin
			// fifo holds at most the pushes not yet emitted
			if (key_in_afull && (push_cnt - emit_cnt) < flow_pkg::FIFO_ALMOST_FULL) begin
				$display("Mismatch at time %0t: key_in_afull expected 0 actual 1", $time);
				mismatch_cnt++;
			end
			if (key_in_wr) begin
				push_cnt++;
			end
			if (out_afull) begin
				afull_cycles++;								// how long downstream is full
			end else begin
				afull_cycles = 0;
			end
			if (key_out_wr) begin
				emit_cnt++;
				// one in-flight record may finish: pop, waits, decide
				if (afull_cycles > flow_pkg::RAM_RD_LATENCY + 3) begin
					$display("Record emitted at time %0t while downstream was stalled", $time);
					stall_cnt++;
				end
				if (exp_recs.size() == 0) begin
					$display("Unexpected record on key_out at time %0t: %h", $time, key_out);
					unexpected_cnt++;
				end else begin
					want_rec = exp_recs.pop_front();
					if (key_out !== want_rec) begin
						$display("Mismatch at time %0t: key_out expected %h actual %h",
							$time, want_rec, key_out);
						mismatch_cnt++;
					end
				end
			end
			if (ack_q && !bus_ack_n && !bus_rw) begin		// falling ack on a read
				if (exp_reads.size() == 0) begin
					$display("Bus read data at time %0t with no expected value queued", $time);
					unexpected_cnt++;
				end else begin
					want_entry = exp_reads.pop_front();
					if (bus_rdata !== want_entry) begin
						$display("Mismatch at time %0t: bus_rdata expected %h actual %h",
							$time, want_entry, bus_rdata);
						mismatch_cnt++;
					end
				end
			end
			ack_q = bus_ack_n;
		end
	end

endmodule

`default_nettype wire

// ==== src/flow_cache_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module flow_cache_top (
	input  wire logic						Clk,
	input  wire logic						Reset_N,
	input  wire flow_pkg::flow_rec_t		key_in,
	input  wire logic						key_in_wr,
	output logic							key_in_afull,	// stop pushing
	output flow_pkg::flow_rec_t				key_out,
	output logic							key_out_wr,
	input  wire logic						out_afull,
	input  wire logic						bus_cs_n,
	input  wire logic						bus_rw,
	input  wire flow_pkg::table_addr_t		bus_addr,
	input  wire flow_pkg::table_entry_t		bus_wdata,
	output flow_pkg::table_entry_t			bus_rdata,
	output logic							bus_ack_n
);

	flow_pkg::flow_rec_t				fifo_q;
	logic								fifo_empty;
	logic								fifo_rd;
	logic [flow_pkg::FIFO_CNT_W-1:0]	fifo_count;

	flow_pkg::table_addr_t				a_addr;				// lookup side
	logic								a_rden;
	logic								a_wren;
	flow_pkg::table_entry_t				a_wdata;
	flow_pkg::table_entry_t				a_rdata;
	flow_pkg::table_addr_t				b_addr;				// management side
	logic								b_rden;
	logic								b_wren;
	flow_pkg::table_entry_t				b_wdata;
	flow_pkg::table_entry_t				b_rdata;

	assign key_in_afull = (fifo_count >= flow_pkg::FIFO_CNT_W'(flow_pkg::FIFO_ALMOST_FULL));

	// ============================================================
	// blocks
	// ============================================================
	key_fifo u_key_fifo (
		.Clk		(Clk),
		.Reset_N	(Reset_N),
		.data		(key_in),
		.wr			(key_in_wr),
		.rd			(fifo_rd),
		.q			(fifo_q),
		.empty		(fifo_empty),
		.count		(fifo_count)
	);

	flow_lookup u_flow_lookup (
		.Clk		(Clk),
		.Reset_N	(Reset_N),
		.fifo_q		(fifo_q),
		.fifo_empty	(fifo_empty),
		.out_afull	(out_afull),
		.ram_rdata	(a_rdata),
		.fifo_rd	(fifo_rd),
		.ram_addr	(a_addr),
		.ram_rden	(a_rden),
		.ram_wren	(a_wren),
		.ram_wdata	(a_wdata),
		.key_out	(key_out),
		.key_out_wr	(key_out_wr)
	);

	mgmt_bus u_mgmt_bus (
		.Clk		(Clk),
		.Reset_N	(Reset_N),
		.bus_cs_n	(bus_cs_n),
		.bus_rw		(bus_rw),
		.bus_addr	(bus_addr),
		.bus_wdata	(bus_wdata),
		.ram_rdata	(b_rdata),
		.bus_rdata	(bus_rdata),
		.bus_ack_n	(bus_ack_n),
		.ram_addr	(b_addr),
		.ram_rden	(b_rden),
		.ram_wren	(b_wren),
		.ram_wdata	(b_wdata)
	);

	flow_table_ram u_flow_table_ram (
		.Clk		(Clk),
		.a_addr		(a_addr),
		.a_rden		(a_rden),
		.a_wren		(a_wren),
		.a_wdata	(a_wdata),
		.a_rdata	(a_rdata),
		.b_addr		(b_addr),
		.b_rden		(b_rden),
		.b_wren		(b_wren),
		.b_wdata	(b_wdata),
		.b_rdata	(b_rdata)
	);

endmodule

`default_nettype wire

// ==== src/mgmt_bus.sv ====
`timescale 1ns/100ps
`default_nettype none

module mgmt_bus (
	input  wire logic						Clk,
	input  wire logic						Reset_N,
	input  wire logic						bus_cs_n,	// low selects
	input  wire logic						bus_rw,		// 1 write, 0 read
	input  wire flow_pkg::table_addr_t		bus_addr,
	input  wire flow_pkg::table_entry_t		bus_wdata,
	input  wire flow_pkg::table_entry_t		ram_rdata,
	output flow_pkg::table_entry_t			bus_rdata,
	output logic							bus_ack_n,	// low until cs released
	output flow_pkg::table_addr_t			ram_addr,
	output logic							ram_rden,
	output logic							ram_wren,
	output flow_pkg::table_entry_t			ram_wdata
);

	typedef enum logic [2:0] {
		B_IDLE,
		B_WRITE,
		B_READ,
		B_WAIT1,
		B_WAIT2,
		B_CAPTURE,
		B_RELEASE
	} bus_state_t;

	bus_state_t		state;

	// ============================================================
	// bus FSM
	// ============================================================
	always_ff @(posedge Clk or negedge Reset_N) begin
		if (!Reset_N) begin
			state		<= B_IDLE;
			bus_ack_n	<= 1'b1;
			ram_rden	<= 1'b0;
			ram_wren	<= 1'b0;
		end else begin
			ram_rden <= 1'b0;									// pulses only
			ram_wren <= 1'b0;
			case (state)
				B_IDLE: begin
					if (!bus_cs_n) begin
						state <= bus_rw ? B_WRITE : B_READ;
					end
				end
				B_WRITE: begin
					ram_wren	<= 1'b1;						// one table write
					bus_ack_n	<= 1'b0;						// ack with the write
					state		<= B_RELEASE;
				end
				B_READ: begin
					ram_rden	<= 1'b1;
					state		<= B_WAIT1;
				end
				B_WAIT1:	state <= B_WAIT2;					// ram pipe stage 1
				B_WAIT2:	state <= B_CAPTURE;					// ram pipe stage 2
				B_CAPTURE: begin
					bus_ack_n	<= 1'b0;						// rdata latched same edge
					state		<= B_RELEASE;
				end
				B_RELEASE: begin
					if (bus_cs_n) begin
						bus_ack_n	<= 1'b1;					// host let go
						state		<= B_IDLE;
					end
				end
				default: begin
					state <= B_IDLE;
				end
			endcase
		end
	end

	// address, write data and read data
	always_ff @(posedge Clk) begin
		if (state == B_WRITE || state == B_READ) begin
			ram_addr	<= bus_addr;
			ram_wdata	<= bus_wdata;
		end
		if (state == B_CAPTURE) begin
			bus_rdata <= ram_rdata;
		end
	end

endmodule

`default_nettype wire

// ==== src/flow_lookup.sv ====
`timescale 1ns/100ps
`default_nettype none

module flow_lookup (
	input  wire logic						Clk,
	input  wire logic						Reset_N,
	input  wire flow_pkg::flow_rec_t		fifo_q,		// head of key fifo
	input  wire logic						fifo_empty,
	input  wire logic						out_afull,	// downstream stall
	input  wire flow_pkg::table_entry_t		ram_rdata,
	output logic							fifo_rd,
	output flow_pkg::table_addr_t			ram_addr,
	output logic							ram_rden,
	output logic							ram_wren,
	output flow_pkg::table_entry_t			ram_wdata,
	output flow_pkg::flow_rec_t				key_out,
	output logic							key_out_wr
);

	typedef enum logic [1:0] {
		S_IDLE,													// wait for a record
		S_WAIT,													// table read in flight
		S_DECIDE,												// rdata valid here
		S_WRITE													// outputs strobe, gap cycle
	} state_t;

	state_t								state;
	logic [flow_pkg::LAT_CNT_W-1:0]		wait_cnt;
	flow_pkg::flow_rec_t				rec_q;					// record being looked up

	logic [flow_pkg::KEY_W-1:0]			rec_key;
	logic [flow_pkg::TIME_W-1:0]		rec_time;
	logic [flow_pkg::IDX_W-1:0]			rec_idx;
	logic [flow_pkg::KEY_W-1:0]			ent_key;
	logic [flow_pkg::CNT_W-1:0]			ent_cnt;
	logic [flow_pkg::TIME_W-1:0]		ent_time;
	logic [flow_pkg::TIME_W:0]			age_bound;				// one extra bit, no wrap
	logic								is_empty;
	logic								is_hit;
	logic								is_stale;
	logic								do_write;
	logic								do_emit;

	// one record at a time, never pop while downstream is full
	assign fifo_rd = (state == S_IDLE) & ~fifo_empty & ~out_afull;

	// ============================================================
	// field split and outcome
	// ============================================================
	assign rec_key	= rec_q[flow_pkg::REC_KEY_LSB +: flow_pkg::KEY_W];
	assign rec_time	= rec_q[flow_pkg::REC_TIME_LSB +: flow_pkg::TIME_W];
	assign rec_idx	= rec_q[flow_pkg::REC_IDX_LSB +: flow_pkg::IDX_W];
	assign ent_key	= ram_rdata[flow_pkg::ENT_KEY_LSB +: flow_pkg::KEY_W];
	assign ent_cnt	= ram_rdata[flow_pkg::ENT_CNT_LSB +: flow_pkg::CNT_W];
	assign ent_time	= ram_rdata[flow_pkg::ENT_TIME_LSB +: flow_pkg::TIME_W];

	assign age_bound	= {1'b0, ent_time} + (flow_pkg::TIME_W + 1)'(flow_pkg::AGE_LIMIT);
	assign is_empty		= (ram_rdata == '0);					// unused slot reads zero
	assign is_hit		= ~is_empty & (ent_key == rec_key);
	assign is_stale		= ~is_empty & ~is_hit & ({1'b0, rec_time} > age_bound);
	assign do_write		= is_empty | is_hit | is_stale;			// overflow leaves slot alone
	assign do_emit		= ~is_empty & ~is_hit;					// evict or overflow

	// ============================================================
	// control
	// ============================================================
	always_ff @(posedge Clk or negedge Reset_N) begin
		if (!Reset_N) begin
			state		<= S_IDLE;
			wait_cnt	<= '0;
			ram_rden	<= 1'b0;
			ram_wren	<= 1'b0;
			key_out_wr	<= 1'b0;
		end else begin
			ram_rden	<= 1'b0;								// single cycle pulses
			ram_wren	<= 1'b0;
			key_out_wr	<= 1'b0;
			case (state)
				S_IDLE: begin
					if (fifo_rd) begin
						ram_rden	<= 1'b1;					// read the bucket
						wait_cnt	<= '0;
						state		<= S_WAIT;
					end
				end
				S_WAIT: begin
					if (wait_cnt == flow_pkg::LAT_CNT_W'(flow_pkg::RAM_RD_LATENCY - 1)) begin
						state <= S_DECIDE;
					end else begin
						wait_cnt <= wait_cnt + 1'b1;
					end
				end
				S_DECIDE: begin
					ram_wren	<= do_write;
					key_out_wr	<= do_emit;
					state		<= S_WRITE;
				end
				S_WRITE: begin
					state <= S_IDLE;							// write visible before next read
				end
				default: begin
					state <= S_IDLE;
				end
			endcase
		end
	end

	// ============================================================
	// datapath, no reset
	// ============================================================
	always_ff @(posedge Clk) begin
		if (fifo_rd) begin
			rec_q		<= fifo_q;								// hold popped record
			ram_addr	<= fifo_q[flow_pkg::REC_IDX_LSB +: flow_pkg::TABLE_ADDR_W];
		end
		if (state == S_DECIDE) begin
			if (is_hit) begin
				ram_wdata <= {ent_key, ent_cnt + 1'b1, rec_time};	// bump count, new time
			end else begin
				ram_wdata <= {rec_key, flow_pkg::CNT_W'(1), rec_time};	// fresh insert
			end
			if (is_stale) begin
				key_out <= {ram_rdata, rec_idx};				// evicted entry goes out
			end else begin
				key_out <= rec_q;								// overflow, pass through
			end
		end
	end

endmodule

`default_nettype wire

// ==== src/flow_table_ram.sv ====
`timescale 1ns/100ps
`default_nettype none

module flow_table_ram (
	input  wire logic						Clk,
	input  wire flow_pkg::table_addr_t		a_addr,		// lookup port
	input  wire logic						a_rden,
	input  wire logic						a_wren,
	input  wire flow_pkg::table_entry_t		a_wdata,
	output flow_pkg::table_entry_t			a_rdata,
	input  wire flow_pkg::table_addr_t		b_addr,		// management port
	input  wire logic						b_rden,
	input  wire logic						b_wren,
	input  wire flow_pkg::table_entry_t		b_wdata,
	output flow_pkg::table_entry_t			b_rdata
);

	flow_pkg::table_entry_t		mem [flow_pkg::TABLE_DEPTH];	// bucket table
	flow_pkg::table_addr_t		addr [2];						// port 0 is a, 1 is b
	logic						rden [2];
	logic						wren [2];
	flow_pkg::table_entry_t		wdata [2];
	flow_pkg::table_entry_t		stage [2];						// first read register
	flow_pkg::table_entry_t		rdata [2];						// second read register

	// all slots empty at start
	initial begin
		for (int i = 0; i < flow_pkg::TABLE_DEPTH; i++) begin
			mem[i] = '0;
		end
	end

	assign addr[0]	= a_addr;
	assign rden[0]	= a_rden;
	assign wren[0]	= a_wren;
	assign wdata[0]	= a_wdata;
	assign addr[1]	= b_addr;
	assign rden[1]	= b_rden;
	assign wren[1]	= b_wren;
	assign wdata[1]	= b_wdata;
	assign a_rdata	= rdata[0];
	assign b_rdata	= rdata[1];

	// same logic on both ports
	always_ff @(posedge Clk) begin
		for (int p = 0; p < 2; p++) begin
			if (wren[p]) begin
				mem[addr[p]] <= wdata[p];						// lands this edge
			end
			if (rden[p]) begin
				stage[p] <= mem[addr[p]];						// old data on collision
			end
			rdata[p] <= stage[p];								// 2 cycles rden to rdata
		end
	end

endmodule

`default_nettype wire

// ==== src/key_fifo.sv ====
`timescale 1ns/100ps
`default_nettype none

module key_fifo (
	input  wire logic							Clk,
	input  wire logic							Reset_N,
	input  wire flow_pkg::flow_rec_t			data,		// record from upstream
	input  wire logic							wr,			// push strobe
	input  wire logic							rd,			// pop, head already on q
	output flow_pkg::flow_rec_t					q,			// show-ahead head word
	output logic								empty,
	output logic [flow_pkg::FIFO_CNT_W-1:0]		count		// words held
);

	flow_pkg::flow_rec_t				mem [flow_pkg::FIFO_DEPTH];	// record storage
	logic [flow_pkg::FIFO_PTR_W-1:0]	wr_ptr;						// next free slot
	logic [flow_pkg::FIFO_PTR_W-1:0]	rd_ptr;						// head slot
	logic								full;
	logic								do_wr;
	logic								do_rd;

	assign full		= (count == flow_pkg::FIFO_CNT_W'(flow_pkg::FIFO_DEPTH));
	assign empty	= (count == '0);
	assign do_wr	= wr & ~full;								// drop push when full
	assign do_rd	= rd & ~empty;								// drop pop when empty
	assign q		= mem[rd_ptr];								// head always visible

	// storage, no reset needed
	always_ff @(posedge Clk) begin
		if (do_wr) begin
			mem[wr_ptr] <= data;
		end
	end

	// ============================================================
	// pointers and occupancy
	// ============================================================
	always_ff @(posedge Clk or negedge Reset_N) begin
		if (!Reset_N) begin
			wr_ptr	<= '0;
			rd_ptr	<= '0;
			count	<= '0;
		end else begin
			if (do_wr) begin
				wr_ptr <= wr_ptr + 1'b1;						// wraps at depth 16
			end
			if (do_rd) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_wr, do_rd})
				2'b10:		count <= count + 1'b1;				// push only
				2'b01:		count <= count - 1'b1;				// pop only
				default:	count <= count;						// both or neither
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== src/flow_pkg.sv ====
`default_nettype none

package flow_pkg;

	// ============================================================
	// field widths
	// ============================================================
	localparam int KEY_W		= 128;							// flow key
	localparam int CNT_W		= 32;							// hit counter
	localparam int TIME_W		= 32;							// timestamp
	localparam int IDX_W		= 32;							// hash index
	localparam int REC_W		= KEY_W + CNT_W + TIME_W + IDX_W;	// 224 bit record
	localparam int ENTRY_W		= KEY_W + CNT_W + TIME_W;		// 192 bit entry

	// record layout, hash index at the bottom
	localparam int REC_IDX_LSB	= 0;
	localparam int REC_TIME_LSB	= REC_IDX_LSB + IDX_W;
	localparam int REC_CNT_LSB	= REC_TIME_LSB + TIME_W;
	localparam int REC_KEY_LSB	= REC_CNT_LSB + CNT_W;			// key on top

	// entry layout is the record minus the index
	localparam int ENT_TIME_LSB	= 0;
	localparam int ENT_CNT_LSB	= ENT_TIME_LSB + TIME_W;
	localparam int ENT_KEY_LSB	= ENT_CNT_LSB + CNT_W;

	// ============================================================
	// sizes, latencies, thresholds
	// ============================================================
	localparam int TABLE_ADDR_W		= 14;						// low bits of hash index
	localparam int TABLE_DEPTH		= 16384;					// bucket slots
	localparam int FIFO_DEPTH		= 16;						// key fifo words
	localparam int FIFO_PTR_W		= 4;						// fifo pointer bits
	localparam int FIFO_CNT_W		= 5;						// holds 0..16
	localparam int FIFO_ALMOST_FULL	= 14;						// afull threshold
	localparam int RAM_RD_LATENCY	= 2;						// table read cycles
	localparam int LAT_CNT_W		= 2;						// wait counter bits
	localparam int AGE_LIMIT		= 100000;					// stale after this

	typedef logic [REC_W-1:0]			flow_rec_t;				// flow record
	typedef logic [ENTRY_W-1:0]			table_entry_t;			// bucket entry
	typedef logic [TABLE_ADDR_W-1:0]	table_addr_t;			// bucket address

endpackage

`default_nettype wire
